// File: regRead_defines.svh
// Register-read stage sizes
`ifndef REGREAD_DEFINES_SVH
`define REGREAD_DEFINES_SVH

// Physical register file
`define PHYS_REGS   64
`define PHYS_LOG    6
`define ARCH_REGS   32    // Ready out of reset
`define DATA_W      32

// Branch checkpoints
`define CHECKPOINTS 4
`define CHK_LOG     2

// Remaining packet fields
`define OPCODE_W    8
`define IMM_W       16
`define PC_W        32

`endif

// File: regReadPkg.sv
// Register-read stage types
`include "regRead_defines.svh"

package regReadPkg;

  typedef logic [`PHYS_LOG-1:0]    physTag_t;
  typedef logic [`DATA_W-1:0]      regData_t;
  typedef logic [`CHECKPOINTS-1:0] chkMask_t;
  typedef logic [`CHK_LOG-1:0]     chkId_t;
  typedef logic [`OPCODE_W-1:0]    opcode_t;
  typedef logic [`IMM_W-1:0]       imm_t;
  typedef logic [`PC_W-1:0]        pc_t;
  typedef logic [`PHYS_REGS-1:0]   readyVec_t;

  // Packet as it leaves the issue queue
  typedef struct packed {
    chkMask_t branchMask;
    physTag_t src1;
    physTag_t src2;
    physTag_t dest;
    opcode_t  opcode;
    imm_t     imm;
    pc_t      pc;
  } issuePkt_t;

  typedef struct packed {
    physTag_t dest;
    regData_t data;
  } wbPkt_t;

  // Issue packet with both operands attached
  typedef struct packed {
    issuePkt_t inst;
    regData_t  opnd1;
    regData_t  opnd2;
  } readPkt_t;

  typedef struct packed {
    logic     valid;
    physTag_t tag;
  } unmapPkt_t;

  // Branch resolution
  typedef struct packed {
    logic   verified;
    logic   mispredict;
    chkId_t chkId;
  } ctrlPkt_t;

endpackage

// File: physRegFile.sv
// Physical register file
`timescale 1ns/1ps
`include "regRead_defines.svh"

module physRegFile (
  input  logic                        clk,
  input  logic                        rstN_i,
  input  regReadPkg::physTag_t  [3:0] rdAddr_i,
  input  regReadPkg::wbPkt_t    [1:0] wbPkt_i,
  input  logic                  [1:0] wbValid_i,
  input  logic                        recover_i,
  output regReadPkg::regData_t  [3:0] rdData_o
);

  import regReadPkg::*;

  regData_t regs [0:`PHYS_REGS-1];

  // Two write ports, blocked during recovery
  always_ff @(posedge clk or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      for (int r = 0; r < `PHYS_REGS; r++)
        regs[r] <= '0;
    end
    else if (!recover_i)
    begin
      for (int w = 0; w < 2; w++)
      begin
        if (wbValid_i[w])
          regs[wbPkt_i[w].dest] <= wbPkt_i[w].data;  // Lane 1 assigned last, wins
      end
    end
  end

  // Registered reads see the contents from before the edge
  always_ff @(posedge clk)
  begin
    for (int p = 0; p < 4; p++)
      rdData_o[p] <= regs[rdAddr_i[p]];
  end

endmodule

// File: issueLane.sv
// Issue lane pipeline register
`timescale 1ns/1ps

module issueLane (
  input  logic                        clk,
  input  logic                        rstN_i,
  input  regReadPkg::issuePkt_t       issuePkt_i,
  input  logic                        issueValid_i,
  input  regReadPkg::wbPkt_t    [1:0] wbPkt_i,
  input  logic                  [1:0] wbValid_i,
  input  regReadPkg::ctrlPkt_t        ctrl_i,
  input  regReadPkg::regData_t  [1:0] rdData_i,
  output regReadPkg::readPkt_t        readPkt_o,
  output logic                        readValid_o
);

  import regReadPkg::*;

  physTag_t  [1:0] srcTag;
  logic      [1:0] fwdHit;
  regData_t  [1:0] fwdData;
  logic            squash;

  issuePkt_t       pktQ;
  logic      [1:0] fwdHitQ;
  regData_t  [1:0] fwdDataQ;

  assign srcTag = {issuePkt_i.src2, issuePkt_i.src1};

  // Writeback lane 1 has priority over lane 0
  always_comb
  begin
    for (int s = 0; s < 2; s++)
    begin
      if (wbValid_i[1] && (wbPkt_i[1].dest == srcTag[s]))
      begin
        fwdHit[s]  = 1'b1;
        fwdData[s] = wbPkt_i[1].data;
      end
      else if (wbValid_i[0] && (wbPkt_i[0].dest == srcTag[s]))
      begin
        fwdHit[s]  = 1'b1;
        fwdData[s] = wbPkt_i[0].data;
      end
      else
      begin
        fwdHit[s]  = 1'b0;
        fwdData[s] = wbPkt_i[0].data;  // Unused on a miss
      end
    end
  end

  // Kill packets that depend on the mispredicted checkpoint
  assign squash = ctrl_i.verified && ctrl_i.mispredict &&
                  issuePkt_i.branchMask[ctrl_i.chkId];

  always_ff @(posedge clk or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      readValid_o <= 1'b0;
      fwdHitQ     <= '0;
    end
    else
    begin
      readValid_o <= issueValid_i && !squash;
      fwdHitQ     <= fwdHit;
    end
  end

  always_ff @(posedge clk)
  begin
    pktQ     <= issuePkt_i;
    fwdDataQ <= fwdData;
  end

  assign readPkt_o.inst  = pktQ;
  assign readPkt_o.opnd1 = fwdHitQ[0] ? fwdDataQ[0] : rdData_i[0];
  assign readPkt_o.opnd2 = fwdHitQ[1] ? fwdDataQ[1] : rdData_i[1];

endmodule

// File: readyScoreboard.sv
// Physical register ready scoreboard
`timescale 1ns/1ps
`include "regRead_defines.svh"

module readyScoreboard (
  input  logic                          clk,
  input  logic                          rstN_i,
  input  logic                          exception_i,
  input  regReadPkg::unmapPkt_t   [1:0] unmapPkt_i,
  input  regReadPkg::physTag_t    [1:0] wakeTag_i,
  input  logic                    [1:0] wakeValid_i,
  input  regReadPkg::wbPkt_t      [1:0] wbPkt_i,
  input  logic                    [1:0] wbValid_i,
  output regReadPkg::readyVec_t         phyRegRdy_o
);

  import regReadPkg::*;

  // Architectural registers ready, the rest pending
  localparam readyVec_t ARCH_READY = readyVec_t'({`ARCH_REGS{1'b1}});

  always_ff @(posedge clk or negedge rstN_i)
  begin
    if (!rstN_i)
      phyRegRdy_o <= ARCH_READY;
    else if (exception_i)
      phyRegRdy_o <= ARCH_READY;
    else
    begin
      for (int u = 0; u < 2; u++)
      begin
        if (unmapPkt_i[u].valid)
          phyRegRdy_o[unmapPkt_i[u].tag] <= 1'b0;
      end
      // Sets come after clears so they win
      for (int k = 0; k < 2; k++)
      begin
        if (wakeValid_i[k])
          phyRegRdy_o[wakeTag_i[k]] <= 1'b1;
        if (wbValid_i[k])
          phyRegRdy_o[wbPkt_i[k].dest] <= 1'b1;
      end
    end
  end

endmodule

// File: regReadTop.sv
// Register-read stage top level
`timescale 1ns/1ps

module regReadTop (
  input  logic                          clk,
  input  logic                          rstN_i,
  input  regReadPkg::issuePkt_t   [1:0] issuePkt_i,
  input  logic                    [1:0] issueValid_i,
  input  regReadPkg::wbPkt_t      [1:0] wbPkt_i,
  input  logic                    [1:0] wbValid_i,
  input  regReadPkg::unmapPkt_t   [1:0] unmapPkt_i,
  input  regReadPkg::physTag_t    [1:0] wakeTag_i,
  input  logic                    [1:0] wakeValid_i,
  input  regReadPkg::ctrlPkt_t          ctrl_i,
  input  logic                          recover_i,
  input  logic                          exception_i,
  output regReadPkg::readPkt_t    [1:0] readPkt_o,
  output logic                    [1:0] readValid_o,
  output regReadPkg::readyVec_t         phyRegRdy_o
);

  import regReadPkg::*;

  physTag_t [3:0] rdAddr;
  regData_t [3:0] rdData;

  // Two read ports per lane, src1 on the even port
  assign rdAddr = {issuePkt_i[1].src2, issuePkt_i[1].src1,
                   issuePkt_i[0].src2, issuePkt_i[0].src1};

  physRegFile uPhysRegFile (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .rdAddr_i  (rdAddr),
    .wbPkt_i   (wbPkt_i),
    .wbValid_i (wbValid_i),
    .recover_i (recover_i),
    .rdData_o  (rdData)
  );

  for (genvar l = 0; l < 2; l++)
  begin : gLane
    issueLane uLane (
      .clk          (clk),
      .rstN_i       (rstN_i),
      .issuePkt_i   (issuePkt_i[l]),
      .issueValid_i (issueValid_i[l]),
      .wbPkt_i      (wbPkt_i),
      .wbValid_i    (wbValid_i),
      .ctrl_i       (ctrl_i),
      .rdData_i     (rdData[2*l +: 2]),
      .readPkt_o    (readPkt_o[l]),
      .readValid_o  (readValid_o[l])
    );
  end

  readyScoreboard uScoreboard (
    .clk         (clk),
    .rstN_i      (rstN_i),
    .exception_i (exception_i),
    .unmapPkt_i  (unmapPkt_i),
    .wakeTag_i   (wakeTag_i),
    .wakeValid_i (wakeValid_i),
    .wbPkt_i     (wbPkt_i),
    .wbValid_i   (wbValid_i),
    .phyRegRdy_o (phyRegRdy_o)
  );

endmodule

// File: regRead_properties.sv
// Register-read stage assertions
`timescale 1ns/1ps
`include "regRead_defines.svh"

module regRead_properties (
  input logic                  clk,
  input logic                  rstN_i,
  input logic            [1:0] issueValid_i,
  input regReadPkg::ctrlPkt_t  ctrl_i,
  input logic                  exception_i,
  input logic            [1:0] readValid_o,
  input regReadPkg::readyVec_t phyRegRdy_o
);

  import regReadPkg::*;

  int assertFails = 0;

  assert property (@(posedge clk) !rstN_i |-> readValid_o == 2'b00)
    else
    begin
      $error("readValid_o high during reset");
      assertFails++;
    end

  // Without a mispredict every issued valid comes through
  assert property (@(posedge clk) disable iff (!rstN_i)
                   !(ctrl_i.verified && ctrl_i.mispredict) |=>
                   readValid_o == $past(issueValid_i))
    else
    begin
      $error("readValid_o differs from issued valid");
      assertFails++;
    end

  assert property (@(posedge clk) disable iff (!rstN_i)
                   exception_i |=>
                   phyRegRdy_o == {{(`PHYS_REGS-`ARCH_REGS){1'b0}}, {`ARCH_REGS{1'b1}}})
    else
    begin
      $error("Ready bits not restored after exception");
      assertFails++;
    end

endmodule

bind regReadTop regRead_properties uProps (.*);

// File: tbRegRead.sv
// Register-read stage testbench
`timescale 1ns/1ps
`include "regRead_defines.svh"

module tbRegRead;

  import regReadPkg::*;

  localparam int PERIOD     = 40;
  localparam int RST_CYCLES = 4;
  localparam int NUM_CYCLES = 2000;
  localparam int TIMEOUT_NS = (RST_CYCLES + NUM_CYCLES + 20) * PERIOD;

  logic                  clk;
  logic                  rstN_i;
  issuePkt_t       [1:0] issuePkt_i;
  logic            [1:0] issueValid_i;
  wbPkt_t          [1:0] wbPkt_i;
  logic            [1:0] wbValid_i;
  unmapPkt_t       [1:0] unmapPkt_i;
  physTag_t        [1:0] wakeTag_i;
  logic            [1:0] wakeValid_i;
  ctrlPkt_t              ctrl_i;
  logic                  recover_i;
  logic                  exception_i;
  readPkt_t        [1:0] readPkt_o;
  logic            [1:0] readValid_o;
  readyVec_t             phyRegRdy_o;

  integer    seed = 32'h75e0;
  regData_t  modelRegs [0:`PHYS_REGS-1];
  readyVec_t modelRdy;
  readPkt_t  expPkt [2];
  logic [1:0] expValid;

  regReadTop i_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  function automatic readyVec_t archPattern();
    readyVec_t v;
    for (int r = 0; r < `PHYS_REGS; r++)
      v[r] = (r < `ARCH_REGS);
    return v;
  endfunction

  // Tags 0..3 and 32..35 so forwarding hits are frequent
  function automatic physTag_t randTag();
    logic [31:0] r;
    r = $random(seed);
    return physTag_t'({r[2], 3'b000, r[1:0]});
  endfunction

  task automatic reportMismatch(input string name, input logic [$bits(readPkt_t)-1:0] expV,
                                input logic [$bits(readPkt_t)-1:0] actV);
    $display("[FAIL] time %0t signal %s expected %h actual %h", $time, name, expV, actV);
    $display("Simulation finished: FAIL");
    $fatal(1, "Mismatch on %s", name);
  endtask

  // Reference model evaluated with the inputs seen at this edge
  task automatic modelStep();
    regData_t opnd [2];
    physTag_t src;
    for (int l = 0; l < 2; l++)
    begin
      for (int s = 0; s < 2; s++)
      begin
        src = (s == 0) ? issuePkt_i[l].src1 : issuePkt_i[l].src2;
        if (wbValid_i[1] && wbPkt_i[1].dest == src)
          opnd[s] = wbPkt_i[1].data;
        else if (wbValid_i[0] && wbPkt_i[0].dest == src)
          opnd[s] = wbPkt_i[0].data;
        else
          opnd[s] = modelRegs[src];
      end
      expPkt[l].inst  = issuePkt_i[l];
      expPkt[l].opnd1 = opnd[0];
      expPkt[l].opnd2 = opnd[1];
      expValid[l] = issueValid_i[l] && !(ctrl_i.verified && ctrl_i.mispredict &&
                                         issuePkt_i[l].branchMask[ctrl_i.chkId]);
    end
    if (!recover_i)
    begin
      for (int w = 0; w < 2; w++)
        if (wbValid_i[w])
          modelRegs[wbPkt_i[w].dest] = wbPkt_i[w].data;  // Lane 1 last
    end
    if (exception_i)
      modelRdy = archPattern();
    else
    begin
      for (int u = 0; u < 2; u++)
        if (unmapPkt_i[u].valid)
          modelRdy[unmapPkt_i[u].tag] = 1'b0;
      for (int k = 0; k < 2; k++)
      begin
        if (wakeValid_i[k])
          modelRdy[wakeTag_i[k]] = 1'b1;
        if (wbValid_i[k])
          modelRdy[wbPkt_i[k].dest] = 1'b1;
      end
    end
  endtask

  task automatic driveRandom();
    issuePkt_t pkt;
    wbPkt_t    wb;
    unmapPkt_t um;
    for (int l = 0; l < 2; l++)
    begin
      pkt.branchMask = chkMask_t'($random(seed));
      pkt.src1       = randTag();
      pkt.src2       = randTag();
      pkt.dest       = randTag();
      pkt.opcode     = opcode_t'($random(seed));
      pkt.imm        = imm_t'($random(seed));
      pkt.pc         = pc_t'($random(seed));
      wb.dest        = randTag();
      wb.data        = regData_t'($random(seed));
      um.valid       = (($random(seed) & 3) == 0);
      um.tag         = randTag();
      issuePkt_i[l]   <= pkt;
      issueValid_i[l] <= 1'($random(seed));
      wbPkt_i[l]      <= wb;
      wbValid_i[l]    <= 1'($random(seed));
      unmapPkt_i[l]   <= um;
      wakeTag_i[l]    <= randTag();
      wakeValid_i[l]  <= (($random(seed) & 3) == 0);
    end
    ctrl_i      <= ctrlPkt_t'($random(seed));
    recover_i   <= (($random(seed) & 3) == 0);
    exception_i <= (($random(seed) & 15) == 0);
  endtask

  task automatic checkOutputs();
    assert (readValid_o === expValid)
      else reportMismatch("readValid_o", expValid, readValid_o);
    assert (readPkt_o[0] === expPkt[0])
      else reportMismatch("readPkt_o[0]", expPkt[0], readPkt_o[0]);
    assert (readPkt_o[1] === expPkt[1])
      else reportMismatch("readPkt_o[1]", expPkt[1], readPkt_o[1]);
    assert (phyRegRdy_o === modelRdy)
      else reportMismatch("phyRegRdy_o", modelRdy, phyRegRdy_o);
  endtask

  initial
  begin
    rstN_i       = 1'b0;
    issuePkt_i   = '0;
    issueValid_i = '0;
    wbPkt_i      = '0;
    wbValid_i    = '0;
    unmapPkt_i   = '0;
    wakeTag_i    = '0;
    wakeValid_i  = '0;
    ctrl_i       = '0;
    recover_i    = 1'b0;
    exception_i  = 1'b0;
    for (int r = 0; r < `PHYS_REGS; r++)
      modelRegs[r] = '0;
    modelRdy = archPattern();
    repeat (RST_CYCLES) @(posedge clk);
    rstN_i <= 1'b1;
    for (int c = 0; c < NUM_CYCLES; c++)
    begin
      @(posedge clk);
      modelStep();
      driveRandom();
      @(negedge clk);  // Outputs settled mid-cycle
      checkOutputs();
    end
    if (i_dut.uProps.assertFails == 0)
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
    else
    begin
      $display("Bound assertions failed %0d times", i_dut.uProps.assertFails);
      $display("Simulation finished: FAIL");
      $fatal(1, "Bound assertion failures");
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the test sequence completed");
    $display("Simulation finished: FAIL");
    $fatal(1, "Timeout");
  end

endmodule

// File: flist.f
+incdir+.
regReadPkg.sv
physRegFile.sv
issueLane.sv
readyScoreboard.sv
regReadTop.sv
regRead_properties.sv
tbRegRead.sv

// File: Bender.yml
package:
  name: reg_read

sources:
  - include_dirs:
      - .
    files:
      - regReadPkg.sv
      - physRegFile.sv
      - issueLane.sv
      - readyScoreboard.sv
      - regReadTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - regRead_properties.sv
      - tbRegRead.sv
